/* hw/front_end_pkg.sv */
package front_end_pkg;

  // front end geometry
  localparam int unsigned num_super = 2;                 // lanes per cycle
  localparam int unsigned num_fb    = 8;                 // fetch buffer entries
  localparam int unsigned fb_idx_w  = $clog2(num_fb);

  // datapath widths
  localparam int unsigned xlen   = 64;
  localparam int unsigned inst_w = 32;

  localparam logic [xlen-1:0] reset_pc = '0;

  // major opcodes used by the test programs
  localparam logic [6:0] op_imm = 7'b0010011;            // addi, xori, ...
  localparam logic [6:0] op_reg = 7'b0110011;            // add, sub, ...

  // one instruction word, read either as register-register or as register-immediate
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm12;                                // signed, bit 11 is the sign
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      logic [6:0]  opcode;
    } i;
  } rv_inst_u;

endpackage

/* hw/fetch_pc_gen.sv */
`timescale 1ns/100ps

module fetch_pc_gen (
  input  logic                                clock,
  input  logic                                arst_n,
  input  logic                                fetch_en,
  input  logic [front_end_pkg::num_super-1:0] imem_valid,
  input  logic                                rollback_en,
  input  logic [front_end_pkg::xlen-1:0]      rollback_pc,
  output logic [front_end_pkg::xlen-1:0]      imem_addr
);
  import front_end_pkg::*;

  logic [xlen-1:0] pc_step;

  // bytes consumed by this fetch
  always_comb begin
    case (imem_valid)
      2'b01:   pc_step = xlen'(4);
      2'b11:   pc_step = xlen'(8);
      default: pc_step = '0;                             // nothing offered
    endcase
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      imem_addr <= reset_pc;
    end else if (rollback_en) begin
      imem_addr <= rollback_pc;                          // restart after a flush
    end else if (fetch_en) begin
      imem_addr <= imem_addr + pc_step;
    end
  end

  // the PC only ever lands on instruction boundaries, including rollback targets
  a_pc_aligned: assert property (@(posedge clock) disable iff (!arst_n)
    imem_addr[1:0] == 2'b00);

  // memory fills lanes in order, a lone lane 1 would skip a word
  a_lane_order: assert property (@(posedge clock) disable iff (!arst_n)
    imem_valid[1] |-> imem_valid[0]);

endmodule

/* hw/fetch_buffer.sv */
`timescale 1ns/100ps

module fetch_buffer (
  input  logic                                                          clock,
  input  logic                                                          arst_n,
  input  logic [front_end_pkg::xlen-1:0]                                imem_addr,
  input  logic [front_end_pkg::num_super-1:0][front_end_pkg::inst_w-1:0] imem_data,
  input  logic [front_end_pkg::num_super-1:0]                           imem_valid,
  input  logic                                                          dispatch_ready,
  input  logic                                                          rollback_en,
  output logic                                                          fetch_en,
  output logic                                                          pair_valid,
  output logic                                                          pop,
  output logic [front_end_pkg::num_super-1:0][front_end_pkg::inst_w-1:0] pair_inst,
  output logic [front_end_pkg::num_super-1:0][front_end_pkg::xlen-1:0]   pair_npc
);
  import front_end_pkg::*;

  // ring storage
  logic [inst_w-1:0] fb_inst [num_fb];
  logic [xlen-1:0]   fb_npc  [num_fb];
  logic [num_fb-1:0] fb_valid;
  logic [num_fb-1:0] fb_valid_nxt;

  logic [fb_idx_w-1:0] head;
  logic [fb_idx_w-1:0] tail;
  logic [fb_idx_w-1:0] head_p1;
  logic [fb_idx_w-1:0] head_nxt;
  logic [fb_idx_w-1:0] tail_p1;
  logic [fb_idx_w-1:0] tail_nxt;

  logic                 want_one;
  logic                 want_two;
  logic [num_super-1:0] wr_en;
  logic [xlen-1:0]      npc0;
  logic [xlen-1:0]      npc1;

  assign head_p1 = head + fb_idx_w'(1);
  assign tail_p1 = tail + fb_idx_w'(1);

  assign want_one = imem_valid[0] & ~imem_valid[1];
  assign want_two = &imem_valid;

  // only take words when every slot they land in is free
  assign fetch_en = ((want_one & ~fb_valid[head]) |
                     (want_two & ~fb_valid[head] & ~fb_valid[head_p1])) & ~rollback_en;

  assign wr_en = imem_valid & {num_super{fetch_en}};

  assign npc0 = imem_addr + xlen'(4);
  assign npc1 = imem_addr + xlen'(8);                    // lane 1 sits at addr + 4

  // oldest two entries go out together
  assign pair_valid = fb_valid[tail] & fb_valid[tail_p1];
  assign pop        = pair_valid & dispatch_ready;

  assign pair_inst[0] = fb_inst[tail];
  assign pair_inst[1] = fb_inst[tail_p1];
  assign pair_npc[0]  = fb_npc[tail];
  assign pair_npc[1]  = fb_npc[tail_p1];

  always_comb begin
    case (wr_en)
      2'b01:   head_nxt = head_p1;
      2'b11:   head_nxt = head + fb_idx_w'(2);
      default: head_nxt = head;
    endcase
  end

  assign tail_nxt = pop ? tail + fb_idx_w'(2) : tail;

  // written and popped slots never overlap, since writes need empty slots
  always_comb begin
    fb_valid_nxt = fb_valid;
    if (wr_en[0]) begin
      fb_valid_nxt[head] = 1'b1;
    end
    if (wr_en[1]) begin
      fb_valid_nxt[head_p1] = 1'b1;
    end
    if (pop) begin
      fb_valid_nxt[tail]    = 1'b0;
      fb_valid_nxt[tail_p1] = 1'b0;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      head     <= '0;
      tail     <= '0;
      fb_valid <= '0;
    end else if (rollback_en) begin
      head     <= '0;                                    // flush everything in flight
      tail     <= '0;
      fb_valid <= '0;
    end else begin
      head     <= head_nxt;
      tail     <= tail_nxt;
      fb_valid <= fb_valid_nxt;
    end
  end

  always_ff @(posedge clock) begin
    if (wr_en[0]) begin
      fb_inst[head] <= imem_data[0];
      fb_npc[head]  <= npc0;
    end
    if (wr_en[1]) begin
      fb_inst[head_p1] <= imem_data[1];
      fb_npc[head_p1]  <= npc1;
    end
  end

  // a popped pair is two neighbouring words of one fetch stream
  a_pop_pair: assert property (@(posedge clock) disable iff (!arst_n)
    pop |-> pair_npc[1] == pair_npc[0] + xlen'(4));

  // the head only meets a live entry once the ring is full
  a_no_overwrite: assert property (@(posedge clock) disable iff (!arst_n)
    fb_valid[head] |-> (head == tail) && (&fb_valid));

endmodule

/* hw/dual_decoder.sv */
`timescale 1ns/100ps

module dual_decoder (
  input  logic                                                          clock,
  input  logic                                                          arst_n,
  input  logic                                                          pop,
  input  logic                                                          rollback_en,
  input  logic [front_end_pkg::num_super-1:0][front_end_pkg::inst_w-1:0] pair_inst,
  input  logic [front_end_pkg::num_super-1:0][front_end_pkg::xlen-1:0]   pair_npc,
  output logic                                                          dec_valid,
  output logic [front_end_pkg::num_super-1:0][front_end_pkg::xlen-1:0]   dec_npc,
  output logic [front_end_pkg::num_super-1:0][6:0]                      dec_opcode,
  output logic [front_end_pkg::num_super-1:0][4:0]                      dec_rd,
  output logic [front_end_pkg::num_super-1:0][4:0]                      dec_rs1,
  output logic [front_end_pkg::num_super-1:0][4:0]                      dec_rs2,
  output logic [front_end_pkg::num_super-1:0][front_end_pkg::xlen-1:0]   dec_imm
);
  import front_end_pkg::*;

  rv_inst_u [num_super-1:0] lane_inst;
  logic     [num_super-1:0][xlen-1:0] lane_imm;

  assign lane_inst = pair_inst;

  // immediate taken from the I view on every word, the back end ignores it when unused
  always_comb begin
    for (int l = 0; l < num_super; l++) begin
      lane_imm[l] = {{(xlen-12){lane_inst[l].i.imm12[11]}}, lane_inst[l].i.imm12};
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      dec_valid <= 1'b0;
    end else if (rollback_en) begin
      dec_valid <= 1'b0;                                 // squash the pair in flight
    end else begin
      dec_valid <= pop;
    end
  end

  // fields hold between pops
  always_ff @(posedge clock) begin
    if (pop) begin
      for (int l = 0; l < num_super; l++) begin
        dec_npc[l]    <= pair_npc[l];
        dec_opcode[l] <= lane_inst[l].r.opcode;
        dec_rd[l]     <= lane_inst[l].r.rd;
        dec_rs1[l]    <= lane_inst[l].r.rs1;
        dec_rs2[l]    <= lane_inst[l].r.rs2;             // garbage for I-type, harmless
        dec_imm[l]    <= lane_imm[l];
      end
    end
  end

endmodule

/* hw/front_end_top.sv */
`timescale 1ns/100ps

module front_end_top (
  input  logic                                                          clock,
  input  logic                                                          arst_n,
  output logic [front_end_pkg::xlen-1:0]                                imem_addr,
  input  logic [front_end_pkg::num_super-1:0][front_end_pkg::inst_w-1:0] imem_data,
  input  logic [front_end_pkg::num_super-1:0]                           imem_valid,
  input  logic                                                          dispatch_ready,
  input  logic                                                          rollback_en,
  input  logic [front_end_pkg::xlen-1:0]                                rollback_pc,
  output logic                                                          dec_valid,
  output logic [front_end_pkg::num_super-1:0][front_end_pkg::xlen-1:0]   dec_npc,
  output logic [front_end_pkg::num_super-1:0][6:0]                      dec_opcode,
  output logic [front_end_pkg::num_super-1:0][4:0]                      dec_rd,
  output logic [front_end_pkg::num_super-1:0][4:0]                      dec_rs1,
  output logic [front_end_pkg::num_super-1:0][4:0]                      dec_rs2,
  output logic [front_end_pkg::num_super-1:0][front_end_pkg::xlen-1:0]   dec_imm
);
  import front_end_pkg::*;

  logic                                fetch_en;
  logic                                pop;
  logic [num_super-1:0][inst_w-1:0]    pair_inst;
  logic [num_super-1:0][xlen-1:0]      pair_npc;

  fetch_pc_gen fetch_pc_gen_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .fetch_en    (fetch_en),
    .imem_valid  (imem_valid),
    .rollback_en (rollback_en),
    .rollback_pc (rollback_pc),
    .imem_addr   (imem_addr)
  );

  fetch_buffer fetch_buffer_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .imem_valid     (imem_valid),
    .dispatch_ready (dispatch_ready),
    .rollback_en    (rollback_en),
    .fetch_en       (fetch_en),
    .pair_valid     (),
    .pop            (pop),
    .pair_inst      (pair_inst),
    .pair_npc       (pair_npc)
  );

  dual_decoder dual_decoder_i (
    .clock       (clock),
    .arst_n      (arst_n),
    .pop         (pop),
    .rollback_en (rollback_en),
    .pair_inst   (pair_inst),
    .pair_npc    (pair_npc),
    .dec_valid   (dec_valid),
    .dec_npc     (dec_npc),
    .dec_opcode  (dec_opcode),
    .dec_rd      (dec_rd),
    .dec_rs1     (dec_rs1),
    .dec_rs2     (dec_rs2),
    .dec_imm     (dec_imm)
  );

endmodule

/* tb/front_end_tb.sv */
`timescale 1ns/100ps

module front_end_tb;
  import front_end_pkg::*;

  localparam int prog_len   = 64;                        // words, even
  localparam int wait_limit = 200;                       // cycles per decoded pair

  logic                             clock;
  logic                             arst_n;
  logic [xlen-1:0]                  imem_addr;
  logic [num_super-1:0][inst_w-1:0] imem_data;
  logic [num_super-1:0]             imem_valid;
  logic                             dispatch_ready;
  logic                             rollback_en;
  logic [xlen-1:0]                  rollback_pc;
  logic                             dec_valid;
  logic [num_super-1:0][xlen-1:0]   dec_npc;
  logic [num_super-1:0][6:0]        dec_opcode;
  logic [num_super-1:0][4:0]        dec_rd;
  logic [num_super-1:0][4:0]        dec_rs1;
  logic [num_super-1:0][4:0]        dec_rs2;
  logic [num_super-1:0][xlen-1:0]   dec_imm;

  rv_inst_u        mem [prog_len];
  logic [xlen-1:0] word_idx;
  integer          seed = 1196;
  int              next_idx;                             // word index of the next expected pair
  logic            stream_done;

  front_end_top dut_i (
    .clock          (clock),
    .arst_n         (arst_n),
    .imem_addr      (imem_addr),
    .imem_data      (imem_data),
    .imem_valid     (imem_valid),
    .dispatch_ready (dispatch_ready),
    .rollback_en    (rollback_en),
    .rollback_pc    (rollback_pc),
    .dec_valid      (dec_valid),
    .dec_npc        (dec_npc),
    .dec_opcode     (dec_opcode),
    .dec_rd         (dec_rd),
    .dec_rs1        (dec_rs1),
    .dec_rs2        (dec_rs2),
    .dec_imm        (dec_imm)
  );

  initial begin
    clock = 1'b0;
    forever #4 clock = ~clock;
  end

  // instruction memory answers in the same cycle
  assign word_idx = imem_addr >> 2;

  always_comb begin
    imem_data[0] = mem[word_idx[5:0]];
    imem_data[1] = mem[word_idx[5:0] + 6'd1];
    if (word_idx < xlen'(prog_len - 1)) begin
      imem_valid = 2'b11;
    end else if (word_idx == xlen'(prog_len - 1)) begin
      imem_valid = 2'b01;                                // last word of the program
    end else begin
      imem_valid = 2'b00;
    end
  end

  task automatic fill_memory();
    rv_inst_u w;
    for (int a = 0; a < prog_len; a++) begin
      w = '0;
      if (($random(seed) & 1) != 0) begin
        w.i.opcode = op_imm;
        w.i.rd     = 5'($random(seed));
        w.i.funct3 = 3'($random(seed));
        w.i.rs1    = 5'($random(seed));
        w.i.imm12  = 12'($random(seed));
      end else begin
        w.r.opcode = op_reg;
        w.r.rd     = 5'($random(seed));
        w.r.funct3 = 3'($random(seed));
        w.r.rs1    = 5'($random(seed));
        w.r.rs2    = 5'($random(seed));
        w.r.funct7 = (($random(seed) & 1) != 0) ? 7'h20 : 7'h00;
      end
      mem[a] = w;
    end
  endtask

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("SIMULATION FAILED");
    $fatal(1);
  endtask

  task automatic report_mismatch(input string name, input logic [xlen-1:0] got,
                                 input logic [xlen-1:0] want);
    fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, want));
  endtask

  task automatic check_bit(input string name, input logic got, input logic want);
    if (got !== want) begin
      report_mismatch(name, xlen'(got), xlen'(want));
    end
  endtask

  task automatic check_pc(input string name, input logic [xlen-1:0] got,
                          input logic [xlen-1:0] want);
    if (got !== want) begin
      report_mismatch(name, got, want);
    end
  endtask

  // decoded fields of one lane against the expected word
  task automatic check_inst(input int lane, input rv_inst_u want);
    longint          imm_s;
    logic [xlen-1:0] want_imm;
    imm_s    = $signed(want.i.imm12);
    want_imm = imm_s;
    if (dec_opcode[lane] !== want.r.opcode) begin
      report_mismatch($sformatf("dec_opcode[%0d]", lane),
                      xlen'(dec_opcode[lane]), xlen'(want.r.opcode));
    end else if (dec_rd[lane] !== want.r.rd) begin
      report_mismatch($sformatf("dec_rd[%0d]", lane), xlen'(dec_rd[lane]), xlen'(want.r.rd));
    end else if (dec_rs1[lane] !== want.r.rs1) begin
      report_mismatch($sformatf("dec_rs1[%0d]", lane),
                      xlen'(dec_rs1[lane]), xlen'(want.r.rs1));
    end else if (dec_rs2[lane] !== want.r.rs2) begin
      report_mismatch($sformatf("dec_rs2[%0d]", lane),
                      xlen'(dec_rs2[lane]), xlen'(want.r.rs2));
    end else if (dec_imm[lane] !== want_imm) begin
      report_mismatch($sformatf("dec_imm[%0d]", lane), dec_imm[lane], want_imm);
    end
  endtask

  task automatic check_next_pair();
    for (int l = 0; l < num_super; l++) begin
      check_inst(l, mem[next_idx + l]);
      check_pc($sformatf("dec_npc[%0d]", l), dec_npc[l], xlen'((next_idx + l + 1) * 4));
    end
    next_idx = next_idx + 2;
  endtask

  // one decoded pair, sampled on the falling edge
  task automatic expect_pair();
    int waited;
    waited = 0;
    @(negedge clock);
    while (dec_valid !== 1'b1 && waited < wait_limit) begin
      @(negedge clock);
      waited++;
    end
    if (dec_valid !== 1'b1) begin
      fail_run($sformatf("no decoded pair for word %0d within %0d cycles", next_idx, wait_limit));
    end else begin
      check_next_pair();
    end
  endtask

  task automatic test_in_order();
    for (int p = 0; p < 8; p++) begin
      expect_pair();
    end
  endtask

  task automatic test_back_pressure();
    logic [xlen-1:0] held_addr;
    held_addr = '0;
    @(posedge clock);
    dispatch_ready <= 1'b0;
    @(negedge clock);
    if (dec_valid === 1'b1) begin
      check_next_pair();                                 // popped on the drop edge
    end
    for (int c = 0; c < 20; c++) begin
      @(negedge clock);
      check_bit("dec_valid", dec_valid, 1'b0);
      if (c == 5) begin
        held_addr = imem_addr;                           // buffer full by now
      end else if (c > 5) begin
        check_pc("imem_addr", imem_addr, held_addr);
      end
    end
    @(posedge clock);
    dispatch_ready <= 1'b1;
    for (int p = 0; p < 6; p++) begin
      expect_pair();
    end
  endtask

  task automatic test_rollback(input int target);
    @(posedge clock);
    rollback_en <= 1'b1;
    rollback_pc <= xlen'(target * 4);
    @(negedge clock);
    if (dec_valid === 1'b1) begin
      check_next_pair();
    end
    @(posedge clock);
    rollback_en <= 1'b0;
    @(negedge clock);
    check_bit("dec_valid", dec_valid, 1'b0);
    check_pc("imem_addr", imem_addr, xlen'(target * 4));
    next_idx = target;
    expect_pair();
  endtask

  task automatic test_random_ready();
    stream_done = 1'b0;
    fork
      begin
        for (int c = 0; c < 5000 && !stream_done; c++) begin
          @(posedge clock);
          dispatch_ready <= 1'($random(seed));
        end
      end
      begin
        while (next_idx < prog_len) begin
          expect_pair();
        end
        stream_done = 1'b1;
      end
    join
    @(posedge clock);
    dispatch_ready <= 1'b1;
    // nothing left once the program is drained
    for (int c = 0; c < 10; c++) begin
      @(negedge clock);
      check_bit("dec_valid", dec_valid, 1'b0);
    end
  endtask

  initial begin
    repeat (20000) @(posedge clock);
    fail_run("run did not finish within 20000 cycles");
  end

  initial begin
    arst_n         = 1'b0;
    dispatch_ready = 1'b1;
    rollback_en    = 1'b0;
    rollback_pc    = '0;
    next_idx       = 0;
    stream_done    = 1'b0;
    fill_memory();
    repeat (9) @(posedge clock);
    @(negedge clock);
    check_pc("imem_addr", imem_addr, reset_pc);
    check_bit("dec_valid", dec_valid, 1'b0);
    @(posedge clock);
    arst_n <= 1'b1;

    test_in_order();
    test_back_pressure();
    test_rollback(8);
    test_random_ready();

    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

/* vlog.f */
hw/front_end_pkg.sv
hw/fetch_pc_gen.sv
hw/fetch_buffer.sv
hw/dual_decoder.sv
hw/front_end_top.sv
tb/front_end_tb.sv

/* run_sim.sh */
#!/bin/sh
# build and run the front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module front_end_tb \
  -f vlog.f

# a failing run still prints its output before the search
out=$(./obj_dir/Vfront_end_tb 2>&1) || true
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "SIMULATION PASSED"; then
  exit 0
else
  exit 1
fi
